// ==== verilog/warpSched_macros.svh ====
`ifndef WARPSCHED_MACROS_SVH
`define WARPSCHED_MACROS_SVH

// hardware warp slots, split into an even and an odd bank
`define WS_NUM_WARPS  8

// task table geometry
`define WS_TASK_DEPTH 256
`define WS_TASK_AW    8

////////////////////
// task word layout, each field runs up to the lsb of the field above it
`define WS_VALID_BIT  28
`define WS_SWID_LSB   20 // software warp id, bits 27..20
`define WS_PC_LSB     11 // start pc, bits 19..11
`define WS_MASK_LSB   3  // active mask, bits 10..3
`define WS_PAIRS_LSB  0  // register pairs, bits 2..0

// byte step of the fetch pc per granted instruction
`define WS_PC_STEP    4

`endif

// ==== verilog/warpSchedPkg.sv ====
`default_nettype none
`include "warpSched_macros.svh"

package warpSchedPkg;

    typedef logic [`WS_VALID_BIT:0] taskWord_t; // one task table entry

    // one bit per hardware slot, one-hot when it names a single warp
    typedef logic [`WS_NUM_WARPS-1:0] warpVec_t;

    typedef logic [31:0] pc_t;
    typedef logic [7:0]  mask_t;     // thread active mask
    typedef logic [7:0]  swWarpId_t;
    typedef logic [5:0]  regCount_t; // wide enough for a full budget of 32

    // a locked warp waits for its branch target from writeback
    typedef enum logic [1:0] {
        wsFree,
        wsRunning,
        wsLocked
    } warpState_e;

endpackage

`default_nettype wire

// ==== verilog/taskTable.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module taskTable (
    input  logic                     Ram_clk,
    input  logic                     rst_n,
    input  logic                     Init_Done,
    input  logic                     Task_Init,
    input  logic [`WS_TASK_AW-1:0]   Task_Init_Addr,
    input  warpSchedPkg::taskWord_t  Task_Init_Data,
    input  logic                     evenLaunch,
    input  logic                     oddLaunch,
    output warpSchedPkg::taskWord_t  evenWord,
    output warpSchedPkg::taskWord_t  oddWord
);

    warpSchedPkg::taskWord_t mem [`WS_TASK_DEPTH]; // distributed ram, loaded before launch
    logic [`WS_TASK_AW-1:0] evenPtr, oddPtr;

    always_ff @(posedge Ram_clk) begin
        if (Task_Init && !Init_Done) begin
            mem[Task_Init_Addr] <= Task_Init_Data;
        end
    end

    // the even pointer walks 0,2,4.. and the odd one 1,3,5..
    always_ff @(posedge Ram_clk or negedge rst_n) begin
        if (!rst_n) begin
            evenPtr <= `WS_TASK_AW'(0);
            oddPtr  <= `WS_TASK_AW'(1);
        end else begin
            if (evenLaunch) evenPtr <= evenPtr + `WS_TASK_AW'(2); // entry consumed
            if (oddLaunch)  oddPtr  <= oddPtr + `WS_TASK_AW'(2);
        end
    end

    assign evenWord = mem[evenPtr]; // asynchronous read, seen by the launcher in this cycle
    assign oddWord  = mem[oddPtr];

    // the table is frozen once the launchers are running
    loadBeforeRun: assert property (@(posedge Ram_clk) disable iff (!rst_n)
        Init_Done |-> !Task_Init)
        else $error("task table written after Init_Done");

endmodule

`default_nettype wire

// ==== verilog/warpLauncher.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module warpLauncher #(
    parameter int BANK = 0 // 0 serves the even slots, 1 the odd slots
) (
    input  logic                     Init_Done,
    input  warpSchedPkg::taskWord_t  word,
    input  warpSchedPkg::warpVec_t   freeSlots,
    input  warpSchedPkg::regCount_t  Num_Of_AviReg,
    output warpSchedPkg::warpVec_t   proposeSlot,
    output warpSchedPkg::regCount_t  proposeRegs,
    output warpSchedPkg::swWarpId_t  proposeSwId
);

    warpSchedPkg::warpVec_t  pick;      // lowest free slot of this bank
    warpSchedPkg::regCount_t need;
    logic                    propose;

    // the entry stores register pairs, so the need is twice the field
    assign need = warpSchedPkg::regCount_t'({word[`WS_MASK_LSB-1:`WS_PAIRS_LSB], 1'b0});

    always_comb begin
        pick = '0;
        for (int k = `WS_NUM_WARPS / 2 - 1; k >= 0; k--) begin // lowest index wins, so scan down
            if (freeSlots[2 * k + BANK]) begin
                pick = '0;
                pick[2 * k + BANK] = 1'b1;
            end
        end
    end

    assign propose = Init_Done && word[`WS_VALID_BIT] && (|pick) && (need <= Num_Of_AviReg);

    assign proposeSlot = propose ? pick : '0;
    assign proposeRegs = propose ? need : '0; // zero keeps the merged count clean
    assign proposeSwId = word[`WS_VALID_BIT-1:`WS_SWID_LSB];

    // a launcher never reaches into the other bank
    always_comb begin
        assert ($onehot0(proposeSlot) &&
                (proposeSlot & (BANK != 0 ? 8'haa : 8'h55)) == proposeSlot)
            else $error("launcher proposed a slot outside its bank");
    end

endmodule

`default_nettype wire

// ==== verilog/warpContext.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module warpContext (
    input  logic                     Ram_clk,
    input  logic                     rst_n,
    input  warpSchedPkg::warpVec_t   evenSlot,
    input  warpSchedPkg::warpVec_t   oddSlot,
    input  warpSchedPkg::regCount_t  evenRegs,
    input  warpSchedPkg::regCount_t  oddRegs,
    input  warpSchedPkg::taskWord_t  evenWord,
    input  warpSchedPkg::taskWord_t  oddWord,
    input  warpSchedPkg::regCount_t  Num_Of_AviReg,
    input  logic                     PC_Update_ID,
    input  logic                     Stall_PC_ID,
    input  warpSchedPkg::warpVec_t   WarpID_from_ID,
    input  warpSchedPkg::pc_t        PC_Update_ID_Addr,
    input  warpSchedPkg::mask_t      Update_ActiveMask_ID,
    input  logic                     PC_Update_WB,
    input  logic [2:0]               WarpID_from_WB,
    input  warpSchedPkg::pc_t        PC_Update_WB_Addr,
    input  warpSchedPkg::mask_t      Update_ActiveMask_WB,
    input  warpSchedPkg::warpVec_t   RAU_Release_Warp_WS,
    input  warpSchedPkg::warpVec_t   grant0,
    input  warpSchedPkg::warpVec_t   grant1,
    output logic                     evenLaunch,
    output logic                     oddLaunch,
    output warpSchedPkg::warpVec_t   freeSlots,
    output warpSchedPkg::warpVec_t   request,
    output warpSchedPkg::pc_t        slotPc [`WS_NUM_WARPS],
    output warpSchedPkg::mask_t      slotMask [`WS_NUM_WARPS],
    output warpSchedPkg::warpVec_t   New_Scheduled_HW_WarpID,
    output warpSchedPkg::regCount_t  New_AllocReg_Num,
    output logic                     Flush_IF,
    output warpSchedPkg::warpVec_t   Flush_Warp
);

    warpSchedPkg::warpState_e state [`WS_NUM_WARPS];
    warpSchedPkg::warpVec_t   running, stallVec, idRedVec, wbVec;

    ////////////////////
    // launch merge under the shared budget
    assign evenLaunch = |evenSlot; // the even launcher already checked its own need
    assign oddLaunch  = (|oddSlot) && (evenRegs + oddRegs <= Num_Of_AviReg);

    assign New_Scheduled_HW_WarpID = evenSlot | (oddLaunch ? oddSlot : '0);
    assign New_AllocReg_Num = evenRegs + (oddLaunch ? oddRegs : '0); // a refused odd retries

    ////////////////////
    // pipeline events, writeback sends a binary index
    assign stallVec = Stall_PC_ID  ? WarpID_from_ID : '0;
    assign idRedVec = PC_Update_ID ? WarpID_from_ID : '0;
    assign wbVec    = PC_Update_WB ? warpSchedPkg::warpVec_t'(1) << WarpID_from_WB : '0;

    always_comb begin
        for (int i = 0; i < `WS_NUM_WARPS; i++) begin
            freeSlots[i] = (state[i] == warpSchedPkg::wsFree);
            running[i]   = (state[i] == warpSchedPkg::wsRunning);
        end
    end

    assign request    = running & ~(stallVec | idRedVec | wbVec); // stale pc must not be fetched
    assign Flush_IF   = Stall_PC_ID || PC_Update_ID; // wb targets a locked warp, nothing to flush
    assign Flush_Warp = stallVec | idRedVec;

    always_ff @(posedge Ram_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WS_NUM_WARPS; i++) begin
                state[i] <= warpSchedPkg::wsFree;
            end
        end else begin
            for (int i = 0; i < `WS_NUM_WARPS; i++) begin
                if (RAU_Release_Warp_WS[i]) begin
                    state[i] <= warpSchedPkg::wsFree;
                end else if (New_Scheduled_HW_WarpID[i]) begin
                    state[i] <= warpSchedPkg::wsRunning;
                end else if (stallVec[i] && running[i]) begin
                    state[i] <= warpSchedPkg::wsLocked; // held until the branch resolves
                end else if (wbVec[i] && state[i] == warpSchedPkg::wsLocked) begin
                    state[i] <= warpSchedPkg::wsRunning;
                end
            end
        end
    end

    // pc and mask, a redirect overrides the fetch step of the same cycle
    always_ff @(posedge Ram_clk) begin
        for (int i = 0; i < `WS_NUM_WARPS; i++) begin
            if (New_Scheduled_HW_WarpID[i]) begin
                slotPc[i]   <= (i % 2 == 1) ?
                    warpSchedPkg::pc_t'(oddWord[`WS_SWID_LSB-1:`WS_PC_LSB]) :
                    warpSchedPkg::pc_t'(evenWord[`WS_SWID_LSB-1:`WS_PC_LSB]);
                slotMask[i] <= (i % 2 == 1) ? oddWord[`WS_PC_LSB-1:`WS_MASK_LSB] :
                                              evenWord[`WS_PC_LSB-1:`WS_MASK_LSB];
            end else if (idRedVec[i]) begin
                slotPc[i]   <= PC_Update_ID_Addr;
                slotMask[i] <= Update_ActiveMask_ID;
            end else if (wbVec[i] && state[i] == warpSchedPkg::wsLocked) begin
                slotPc[i]   <= PC_Update_WB_Addr;
                slotMask[i] <= Update_ActiveMask_WB;
            end else if (grant0[i] || grant1[i]) begin
                slotPc[i] <= slotPc[i] + `WS_PC_STEP;
            end
        end
    end

    // a branch target only ever comes back for a warp that the decoder stalled
    wbOnLocked: assert property (@(posedge Ram_clk) disable iff (!rst_n)
        PC_Update_WB |-> state[WarpID_from_WB] == warpSchedPkg::wsLocked)
        else $error("writeback redirect to a warp that is not locked");

endmodule

`default_nettype wire

// ==== verilog/fetchArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module fetchArbiter (
    input  logic                    Ram_clk,
    input  logic                    rst_n,
    input  warpSchedPkg::warpVec_t  request,
    input  warpSchedPkg::pc_t       slotPc [`WS_NUM_WARPS],
    input  warpSchedPkg::mask_t     slotMask [`WS_NUM_WARPS],
    output warpSchedPkg::warpVec_t  grant0,
    output warpSchedPkg::warpVec_t  grant1,
    output warpSchedPkg::warpVec_t  WS_IF_WarpID0,
    output warpSchedPkg::warpVec_t  WS_IF_WarpID1,
    output warpSchedPkg::pc_t       WS_IF_PC_Warp0,
    output warpSchedPkg::pc_t       WS_IF_PC_Warp1,
    output warpSchedPkg::pc_t       WS_IF_PC0_Plus4,
    output warpSchedPkg::pc_t       WS_IF_PC1_Plus4,
    output warpSchedPkg::mask_t     WS_IF_Active_Mask0,
    output warpSchedPkg::mask_t     WS_IF_Active_Mask1
);

    logic [2:0] ptr, nextPtr; // slot with the highest priority this cycle

    // walk once round from the pointer, the first two requesters win
    always_comb begin
        logic [2:0] idx;
        grant0  = '0;
        grant1  = '0;
        nextPtr = ptr;
        for (int k = 0; k < `WS_NUM_WARPS; k++) begin
            idx = ptr + 3'(k);
            if (request[idx] && grant0 == '0) begin
                grant0[idx] = 1'b1;
                nextPtr     = idx + 3'd1;
            end else if (request[idx] && grant1 == '0) begin
                grant1[idx] = 1'b1;
                nextPtr     = idx + 3'd1; // past the second grant
            end
        end
    end

    always_ff @(posedge Ram_clk or negedge rst_n) begin
        if (!rst_n) ptr <= 3'd0;
        else        ptr <= nextPtr; // unchanged when nobody asks
    end

    ////////////////////
    // fetch mux, an all-zero id tells fetch there is nothing to do
    always_comb begin
        WS_IF_PC_Warp0     = '0;
        WS_IF_PC_Warp1     = '0;
        WS_IF_Active_Mask0 = '0;
        WS_IF_Active_Mask1 = '0;
        for (int i = 0; i < `WS_NUM_WARPS; i++) begin
            if (grant0[i]) begin
                WS_IF_PC_Warp0     = slotPc[i];
                WS_IF_Active_Mask0 = slotMask[i];
            end
            if (grant1[i]) begin
                WS_IF_PC_Warp1     = slotPc[i];
                WS_IF_Active_Mask1 = slotMask[i];
            end
        end
    end

    assign WS_IF_WarpID0   = grant0;
    assign WS_IF_WarpID1   = grant1;
    assign WS_IF_PC0_Plus4 = WS_IF_PC_Warp0 + `WS_PC_STEP;
    assign WS_IF_PC1_Plus4 = WS_IF_PC_Warp1 + `WS_PC_STEP;

    // both fetch lanes must carry different warps
    grantsDisjoint: assert property (@(posedge Ram_clk) disable iff (!rst_n)
        (grant0 & grant1) == '0)
        else $error("fetch grants overlap");

endmodule

`default_nettype wire

// ==== verilog/warpSched.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module warpSched (
    input  logic                     Ram_clk,
    input  logic                     rst_n,
    input  logic                     Init_Done,
    input  logic                     Task_Init,
    input  logic [`WS_TASK_AW-1:0]   Task_Init_Addr,
    input  warpSchedPkg::taskWord_t  Task_Init_Data,
    input  warpSchedPkg::regCount_t  Num_Of_AviReg,
    input  logic                     PC_Update_ID,
    input  logic                     Stall_PC_ID,
    input  warpSchedPkg::warpVec_t   WarpID_from_ID,
    input  warpSchedPkg::pc_t        PC_Update_ID_Addr,
    input  warpSchedPkg::mask_t      Update_ActiveMask_ID,
    input  logic                     PC_Update_WB,
    input  logic [2:0]               WarpID_from_WB,
    input  warpSchedPkg::pc_t        PC_Update_WB_Addr,
    input  warpSchedPkg::mask_t      Update_ActiveMask_WB,
    input  warpSchedPkg::warpVec_t   RAU_Release_Warp_WS,
    output warpSchedPkg::warpVec_t   WS_IF_WarpID0,
    output warpSchedPkg::warpVec_t   WS_IF_WarpID1,
    output warpSchedPkg::pc_t        WS_IF_PC_Warp0,
    output warpSchedPkg::pc_t        WS_IF_PC_Warp1,
    output warpSchedPkg::pc_t        WS_IF_PC0_Plus4,
    output warpSchedPkg::pc_t        WS_IF_PC1_Plus4,
    output warpSchedPkg::mask_t      WS_IF_Active_Mask0,
    output warpSchedPkg::mask_t      WS_IF_Active_Mask1,
    output logic                     Flush_IF,
    output warpSchedPkg::warpVec_t   Flush_Warp,
    output warpSchedPkg::warpVec_t   New_Scheduled_HW_WarpID,
    output warpSchedPkg::regCount_t  New_AllocReg_Num,
    output warpSchedPkg::swWarpId_t  WS_SwID_Even,
    output warpSchedPkg::swWarpId_t  WS_SwID_Odd
);

    warpSchedPkg::taskWord_t  evenWord, oddWord;
    warpSchedPkg::warpVec_t   evenSlot, oddSlot, freeSlots, request, grant0, grant1;
    warpSchedPkg::regCount_t  evenRegs, oddRegs;
    warpSchedPkg::pc_t        slotPc [`WS_NUM_WARPS];
    warpSchedPkg::mask_t      slotMask [`WS_NUM_WARPS];
    logic                     evenLaunch, oddLaunch;

    taskTable u_table (
        .Ram_clk, .rst_n, .Init_Done, .Task_Init, .Task_Init_Addr, .Task_Init_Data,
        .evenLaunch, .oddLaunch, .evenWord, .oddWord
    );

    ////////////////////
    // one launcher per bank, they run side by side
    warpLauncher #(.BANK(0)) u_even (
        .Init_Done, .word(evenWord), .freeSlots, .Num_Of_AviReg,
        .proposeSlot(evenSlot), .proposeRegs(evenRegs), .proposeSwId(WS_SwID_Even)
    );

    warpLauncher #(.BANK(1)) u_odd (
        .Init_Done, .word(oddWord), .freeSlots, .Num_Of_AviReg,
        .proposeSlot(oddSlot), .proposeRegs(oddRegs), .proposeSwId(WS_SwID_Odd)
    );

    warpContext u_context (
        .Ram_clk, .rst_n, .evenSlot, .oddSlot, .evenRegs, .oddRegs, .evenWord, .oddWord,
        .Num_Of_AviReg, .PC_Update_ID, .Stall_PC_ID, .WarpID_from_ID, .PC_Update_ID_Addr,
        .Update_ActiveMask_ID, .PC_Update_WB, .WarpID_from_WB, .PC_Update_WB_Addr,
        .Update_ActiveMask_WB, .RAU_Release_Warp_WS, .grant0, .grant1,
        .evenLaunch, .oddLaunch, .freeSlots, .request, .slotPc, .slotMask,
        .New_Scheduled_HW_WarpID, .New_AllocReg_Num, .Flush_IF, .Flush_Warp
    );

    fetchArbiter u_arbiter (
        .Ram_clk, .rst_n, .request, .slotPc, .slotMask, .grant0, .grant1,
        .WS_IF_WarpID0, .WS_IF_WarpID1, .WS_IF_PC_Warp0, .WS_IF_PC_Warp1,
        .WS_IF_PC0_Plus4, .WS_IF_PC1_Plus4, .WS_IF_Active_Mask0, .WS_IF_Active_Mask1
    );

endmodule

`default_nettype wire

// ==== verif/warpSchedVectors.svh ====
`ifndef WARPSCHEDVECTORS_SVH
`define WARPSCHEDVECTORS_SVH

// columns: name, action, budget, warp, wb index, pc, mask, cycles,
// expected launch vector, even entry, odd entry (-1 means no launch from that bank)

typedef enum {actLoad, actWait, actStall, actIdRedirect, actWbRedirect, actRelease} action_e;

typedef struct {
    string                   name;
    action_e                 action;
    int                      budget;    // -1 asks for the larger single need of the pair
    warpSchedPkg::warpVec_t  warp;      // a wait with a warp set waits for its grant
    logic [2:0]              idx;
    warpSchedPkg::pc_t       pc;
    warpSchedPkg::mask_t     mask;
    int                      cycles;    // idle length, or the timeout of a grant wait
    warpSchedPkg::warpVec_t  expLaunch;
    int                      evenEntry;
    int                      oddEntry;
} testVector_t;

localparam int NUM_VECTORS = 15;

testVector_t vectors [NUM_VECTORS] = '{
    '{"idleStart",     actWait,       0,  8'h00, 3'd0, 32'h0,   8'h00, 3,  8'h00, -1, -1},
    '{"launchPair",    actLoad,       31, 8'h00, 3'd0, 32'h0,   8'h00, 1,  8'h03, 0,  1},
    '{"fetchTwo",      actWait,       0,  8'h00, 3'd0, 32'h0,   8'h00, 6,  8'h00, -1, -1},
    '{"budgetEven",    actLoad,       -1, 8'h00, 3'd0, 32'h0,   8'h00, 1,  8'h04, 2,  -1},
    '{"budgetRaised",  actLoad,       31, 8'h00, 3'd0, 32'h0,   8'h00, 1,  8'h18, 4,  3},
    '{"fetchFive",     actWait,       0,  8'h00, 3'd0, 32'h0,   8'h00, 8,  8'h00, -1, -1},
    '{"stallWarp1",    actStall,      0,  8'h02, 3'd0, 32'h0,   8'h00, 1,  8'h00, -1, -1},
    '{"stallHold",     actWait,       0,  8'h00, 3'd0, 32'h0,   8'h00, 6,  8'h00, -1, -1},
    '{"wbResume",      actWbRedirect, 0,  8'h00, 3'd1, 32'h200, 8'h0f, 1,  8'h00, -1, -1},
    '{"wbFetch",       actWait,       0,  8'h02, 3'd0, 32'h0,   8'h00, 20, 8'h00, -1, -1},
    '{"idRedirect0",   actIdRedirect, 0,  8'h01, 3'd0, 32'h340, 8'hf0, 1,  8'h00, -1, -1},
    '{"idFetch",       actWait,       0,  8'h01, 3'd0, 32'h0,   8'h00, 20, 8'h00, -1, -1},
    '{"releaseSlot0",  actRelease,    0,  8'h01, 3'd0, 32'h0,   8'h00, 1,  8'h00, -1, -1},
    '{"relaunch",      actLoad,       31, 8'h00, 3'd0, 32'h0,   8'h00, 1,  8'h21, 6,  5},
    '{"finalRun",      actWait,       0,  8'h00, 3'd0, 32'h0,   8'h00, 6,  8'h00, -1, -1}
};

`endif

// ==== verif/tbWarpSched.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "warpSched_macros.svh"

module tbWarpSched;

    logic                     Ram_clk, rst_n, Init_Done, Task_Init;
    logic [`WS_TASK_AW-1:0]   Task_Init_Addr;
    warpSchedPkg::taskWord_t  Task_Init_Data;
    warpSchedPkg::regCount_t  Num_Of_AviReg;
    logic                     PC_Update_ID, Stall_PC_ID, PC_Update_WB;
    warpSchedPkg::warpVec_t   WarpID_from_ID, RAU_Release_Warp_WS;
    warpSchedPkg::pc_t        PC_Update_ID_Addr, PC_Update_WB_Addr;
    warpSchedPkg::mask_t      Update_ActiveMask_ID, Update_ActiveMask_WB;
    logic [2:0]               WarpID_from_WB;
    warpSchedPkg::warpVec_t   WS_IF_WarpID0, WS_IF_WarpID1, Flush_Warp, New_Scheduled_HW_WarpID;
    warpSchedPkg::pc_t        WS_IF_PC_Warp0, WS_IF_PC_Warp1, WS_IF_PC0_Plus4, WS_IF_PC1_Plus4;
    warpSchedPkg::mask_t      WS_IF_Active_Mask0, WS_IF_Active_Mask1;
    logic                     Flush_IF;
    warpSchedPkg::regCount_t  New_AllocReg_Num;
    warpSchedPkg::swWarpId_t  WS_SwID_Even, WS_SwID_Odd;

    warpSchedPkg::taskWord_t  words [8]; // only the first eight entries carry tasks
    warpSchedPkg::warpState_e mState [`WS_NUM_WARPS]; // reference copy of the slot states
    warpSchedPkg::pc_t        mPc [`WS_NUM_WARPS];
    warpSchedPkg::mask_t      mMask [`WS_NUM_WARPS];
    logic [2:0]               mPtr; // expected arbiter pointer
    string                    curTest;
    int                       errors, testErrors, failedTests;
    logic                     granted;

    `include "warpSchedVectors.svh"

    warpSched i_dut (.*);

    initial begin
        Ram_clk = 1'b0;
        forever #5 Ram_clk = ~Ram_clk;
    end

    // hard limit on the whole run
    initial begin
        #20000;
        $display("simulation ran past its time limit without finishing");
        $display("Verification failed");
        $finish;
    end

    ////////////////////
    // one compare task per result type
    task automatic checkVec(input string what, input warpSchedPkg::warpVec_t act, exp);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic checkPc(input string what, input warpSchedPkg::pc_t act, exp);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic checkMask(input string what, input warpSchedPkg::mask_t act, exp);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic checkRegs(input string what, input warpSchedPkg::regCount_t act, exp);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %0d, actual %0d", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    // an entry needs two registers per pair
    function automatic warpSchedPkg::regCount_t needOf(input int e);
        return warpSchedPkg::regCount_t'(2 * words[e][`WS_MASK_LSB-1:`WS_PAIRS_LSB]);
    endfunction

    function automatic warpSchedPkg::pc_t pcOf(input warpSchedPkg::warpVec_t v);
        for (int i = 0; i < `WS_NUM_WARPS; i++) if (v[i]) return mPc[i];
        return '0; // no grant gives a zero pc
    endfunction

    function automatic warpSchedPkg::mask_t maskOf(input warpSchedPkg::warpVec_t v);
        for (int i = 0; i < `WS_NUM_WARPS; i++) if (v[i]) return mMask[i];
        return '0;
    endfunction

    task automatic clearInputs();
        Task_Init           = 1'b0;
        Num_Of_AviReg       = '0; // every need is at least 2, so nothing launches
        PC_Update_ID        = 1'b0;
        Stall_PC_ID         = 1'b0;
        PC_Update_WB        = 1'b0;
        WarpID_from_ID      = '0;
        RAU_Release_Warp_WS = '0;
    endtask

    ////////////////////
    // predict and check one cycle, then step the reference state
    task automatic evalCycle(input warpSchedPkg::warpVec_t launch, input int eEnt, oEnt);
        warpSchedPkg::warpVec_t  req, evt, g0, g1, wbVec, idVec;
        warpSchedPkg::regCount_t regs;
        logic [2:0]              idx, nptr;
        int                      e;
        wbVec = PC_Update_WB ? warpSchedPkg::warpVec_t'(1) << WarpID_from_WB : '0;
        idVec = (Stall_PC_ID || PC_Update_ID) ? WarpID_from_ID : '0;
        evt   = idVec | wbVec;
        g0    = '0;
        g1    = '0;
        nptr  = mPtr;
        for (int i = 0; i < `WS_NUM_WARPS; i++) begin
            req[i] = (mState[i] == warpSchedPkg::wsRunning) && !evt[i];
        end
        for (int k = 0; k < `WS_NUM_WARPS; k++) begin // rotate from the pointer
            idx = mPtr + 3'(k);
            if (req[idx] && g0 == '0) begin
                g0[idx] = 1'b1;
                nptr    = idx + 3'd1;
            end else if (req[idx] && g1 == '0) begin
                g1[idx] = 1'b1;
                nptr    = idx + 3'd1;
            end
        end
        checkVec("grant0", WS_IF_WarpID0, g0);
        checkVec("grant1", WS_IF_WarpID1, g1);
        checkPc("pc0", WS_IF_PC_Warp0, pcOf(g0));
        checkPc("pc1", WS_IF_PC_Warp1, pcOf(g1));
        checkPc("pc0Plus4", WS_IF_PC0_Plus4, pcOf(g0) + 32'd4);
        checkPc("pc1Plus4", WS_IF_PC1_Plus4, pcOf(g1) + 32'd4);
        checkMask("mask0", WS_IF_Active_Mask0, maskOf(g0));
        checkMask("mask1", WS_IF_Active_Mask1, maskOf(g1));
        checkVec("flushWarp", Flush_Warp, idVec);
        checkVec("flushIF", warpSchedPkg::warpVec_t'(Flush_IF),
                 warpSchedPkg::warpVec_t'(Stall_PC_ID || PC_Update_ID));
        regs = '0;
        if (eEnt >= 0) regs = regs + needOf(eEnt);
        if (oEnt >= 0) regs = regs + needOf(oEnt);
        checkVec("launch", New_Scheduled_HW_WarpID, launch);
        checkRegs("allocRegs", New_AllocReg_Num, regs);
        if (eEnt >= 0) checkVec("swIdEven", WS_SwID_Even, words[eEnt][27:20]);
        if (oEnt >= 0) checkVec("swIdOdd", WS_SwID_Odd, words[oEnt][27:20]);
        for (int i = 0; i < `WS_NUM_WARPS; i++) begin
            e = (i % 2 == 1) ? oEnt : eEnt;
            // the pc update goes first since it looks at the state before this edge
            if (launch[i]) begin
                mPc[i]   = warpSchedPkg::pc_t'(words[e][`WS_SWID_LSB-1:`WS_PC_LSB]);
                mMask[i] = words[e][`WS_PC_LSB-1:`WS_MASK_LSB];
            end else if (PC_Update_ID && WarpID_from_ID[i]) begin
                mPc[i]   = PC_Update_ID_Addr;
                mMask[i] = Update_ActiveMask_ID;
            end else if (wbVec[i] && mState[i] == warpSchedPkg::wsLocked) begin
                mPc[i]   = PC_Update_WB_Addr;
                mMask[i] = Update_ActiveMask_WB;
            end else if (g0[i] || g1[i]) begin
                mPc[i] = mPc[i] + 32'd4;
            end
            if (RAU_Release_Warp_WS[i]) mState[i] = warpSchedPkg::wsFree;
            else if (launch[i]) mState[i] = warpSchedPkg::wsRunning;
            else if (Stall_PC_ID && WarpID_from_ID[i] && mState[i] == warpSchedPkg::wsRunning)
                mState[i] = warpSchedPkg::wsLocked;
            else if (wbVec[i] && mState[i] == warpSchedPkg::wsLocked)
                mState[i] = warpSchedPkg::wsRunning;
        end
        mPtr = nptr;
    endtask

    task automatic idleCycle();
        @(negedge Ram_clk);
        clearInputs();
        #1 evalCycle('0, -1, -1);
    endtask

    ////////////////////
    initial begin
        void'($urandom(60809));
        rst_n = 1'b0;
        Init_Done = 1'b0;
        Task_Init_Addr = '0;
        Task_Init_Data = '0;
        WarpID_from_WB = '0;
        PC_Update_ID_Addr = '0;
        PC_Update_WB_Addr = '0;
        Update_ActiveMask_ID = '0;
        Update_ActiveMask_WB = '0;
        clearInputs();
        errors = 0;
        failedTests = 0;
        mPtr = 3'd0;
        for (int i = 0; i < `WS_NUM_WARPS; i++) mState[i] = warpSchedPkg::wsFree;
        for (int i = 0; i < 8; i++) begin
            words[i] = warpSchedPkg::taskWord_t'($urandom);
            words[i][`WS_VALID_BIT] = 1'b1;
            if (words[i][2:0] == 3'd0) words[i][0] = 1'b1; // keep every need nonzero
        end
        repeat (10) @(negedge Ram_clk);
        rst_n = 1'b1;
        for (int a = 0; a < `WS_TASK_DEPTH; a++) begin // unused entries stay invalid
            @(negedge Ram_clk);
            Task_Init      = 1'b1;
            Task_Init_Addr = `WS_TASK_AW'(a);
            Task_Init_Data = (a < 8) ? words[a] : '0;
        end
        @(negedge Ram_clk);
        Task_Init = 1'b0;
        Init_Done = 1'b1;
        for (int r = 0; r < NUM_VECTORS; r++) begin
            curTest    = vectors[r].name;
            testErrors = 0;
            @(negedge Ram_clk);
            clearInputs();
            case (vectors[r].action)
                actLoad: begin
                    if (vectors[r].budget >= 0) Num_Of_AviReg = 6'(vectors[r].budget);
                    else if (needOf(2) > needOf(3)) Num_Of_AviReg = needOf(2);
                    else Num_Of_AviReg = needOf(3); // each fits, the pair does not
                end
                actStall: begin
                    Stall_PC_ID    = 1'b1;
                    WarpID_from_ID = vectors[r].warp;
                end
                actIdRedirect: begin
                    PC_Update_ID         = 1'b1;
                    WarpID_from_ID       = vectors[r].warp;
                    PC_Update_ID_Addr    = vectors[r].pc;
                    Update_ActiveMask_ID = vectors[r].mask;
                end
                actWbRedirect: begin
                    PC_Update_WB         = 1'b1;
                    WarpID_from_WB       = vectors[r].idx;
                    PC_Update_WB_Addr    = vectors[r].pc;
                    Update_ActiveMask_WB = vectors[r].mask;
                end
                actRelease: RAU_Release_Warp_WS = vectors[r].warp;
                default: ;
            endcase
            #1 evalCycle(vectors[r].expLaunch, vectors[r].evenEntry, vectors[r].oddEntry);
            if (vectors[r].action == actWait && vectors[r].warp == '0) begin
                for (int n = 1; n < vectors[r].cycles; n++) idleCycle();
            end else if (vectors[r].action == actWait) begin
                // wait for the warp to show up on a fetch lane
                granted = ((WS_IF_WarpID0 | WS_IF_WarpID1) & vectors[r].warp) != '0;
                for (int n = 0; n < vectors[r].cycles && !granted; n++) begin
                    idleCycle();
                    granted = ((WS_IF_WarpID0 | WS_IF_WarpID1) & vectors[r].warp) != '0;
                end
                if (!granted) begin
                    $display("%s: warp %h got no fetch grant within %0d cycles",
                             curTest, vectors[r].warp, vectors[r].cycles);
                    testErrors++;
                end
            end
            errors += testErrors;
            if (testErrors != 0) failedTests++;
            $display("test %s: %s", curTest, (testErrors == 0) ? "ok" : "FAILED");
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_VECTORS, failedTests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== warpSched.f ====
+incdir+verilog
+incdir+verif
verilog/warpSchedPkg.sv
verilog/taskTable.sv
verilog/warpLauncher.sv
verilog/warpContext.sv
verilog/fetchArbiter.sv
verilog/warpSched.sv
verif/tbWarpSched.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tbWarpSched
FLIST = warpSched.f
LOG   = sim.log
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
